/* filelist.f */
source/cfg_pkg.sv
source/cfg_serializer.sv
source/cfg_node.sv
source/cfg_chain_top.sv
tests/cfg_chain_tb.sv

/* Bender.yml */
package:
  name: cfg_chain

sources:
  - files:
      - source/cfg_pkg.sv
      - source/cfg_serializer.sv
      - source/cfg_node.sv
      - source/cfg_chain_top.sv
  - target: test
    files:
      - tests/cfg_chain_tb.sv

/* tests/cfg_chain_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cfg_chain_tb
  import cfg_pkg::*;
();

  localparam logic [cfg_id_w-1:0] node_a_id = 4'd1;
  localparam logic [cfg_id_w-1:0] node_b_id = 4'd2;
  localparam logic [cfg_id_w-1:0] node_c_id = 4'd3;
  localparam logic [7:0]  def_a = 8'h5A;
  localparam logic [11:0] def_b = 12'h3C0;
  localparam logic [15:0] def_c = 16'hBEEF;

  localparam int kind_write = 0;              // Plain write request
  localparam int kind_reset = 1;              // Broadcast reset alone
  localparam int kind_both  = 2;              // Broadcast reset with a write also raised

  // About 40 frames of about 30 cycles, with a wide margin
  localparam int max_frames     = 40;
  localparam int frame_cycles   = cfg_frame_w + 4;
  localparam int timeout_cycles = max_frames * frame_cycles * 10 / 3;

  logic                  clk_i;
  logic                  reset;
  logic                  wr_valid_i;
  logic [cfg_id_w-1:0]   wr_id_i;
  logic [cfg_data_w-1:0] wr_data_i;
  logic                  reset_all_i;
  logic                  busy_o;
  logic [7:0]            cfg_a_o;
  logic [11:0]           cfg_b_o;
  logic [15:0]           cfg_c_o;

  logic [7:0]  exp_a;                         // Model of node A
  logic [11:0] exp_b;                         // Model of node B
  logic [15:0] exp_c;                         // Model of node C

  int                  q_kind[$];             // Requests of the running test
  logic [cfg_id_w-1:0] q_id[$];
  logic [cfg_data_w-1:0] q_data[$];

  logic [31:0] lcg_state = 32'd10881;
  int          cycle_cnt;
  int          busy_len = 0;                  // Cycles of the frame now going out
  int          check_errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;

  cfg_chain_top cfg_chain_top_inst (
    .clk_i       (clk_i),
    .reset       (reset),
    .wr_valid_i  (wr_valid_i),
    .wr_id_i     (wr_id_i),
    .wr_data_i   (wr_data_i),
    .reset_all_i (reset_all_i),
    .busy_o      (busy_o),
    .cfg_a_o     (cfg_a_o),
    .cfg_b_o     (cfg_b_o),
    .cfg_c_o     (cfg_c_o)
  );

  always #20 clk_i = ~clk_i;                  // 40 ns period

  // One frame keeps busy_o high for cfg_frame_w cycles
  always @(negedge clk_i) begin
    if (busy_o) begin
      busy_len++;
    end else if (busy_len != 0) begin
      assert (busy_len == cfg_frame_w) else begin
        $display("Error at %0t ns: busy_o high for %0d cycles, expected %0d",
                 $time, busy_len, cfg_frame_w);
        check_errors++;
      end
      busy_len = 0;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic void model_defaults();
    exp_a = def_a;
    exp_b = def_b;
    exp_c = def_c;
  endfunction

  // Matching node takes the low payload bits, other IDs change nothing
  function automatic void model_apply(input int idx);
    if (q_kind[idx] != kind_write) begin
      model_defaults();
    end else begin
      case (q_id[idx])
        node_a_id: exp_a = q_data[idx][7:0];
        node_b_id: exp_b = q_data[idx][11:0];
        node_c_id: exp_c = q_data[idx];
        default: ;                            // Unassigned ID
      endcase
    end
  endfunction

  task automatic drive_idle();
    wr_valid_i  = 1'b0;
    reset_all_i = 1'b0;
    wr_id_i     = '0;
    wr_data_i   = '0;
  endtask

  task automatic drive_request(input int idx);
    wr_valid_i  = (q_kind[idx] != kind_reset);
    reset_all_i = (q_kind[idx] != kind_write);
    wr_id_i     = q_id[idx];
    wr_data_i   = q_data[idx];
  endtask

  task automatic queue_write(input logic [cfg_id_w-1:0] id, input logic [cfg_data_w-1:0] data);
    q_kind.push_back(kind_write);
    q_id.push_back(id);
    q_data.push_back(data);
  endtask

  // With kind_both a write of zero to node C rides along and must lose
  task automatic queue_reset_all(input int kind);
    q_kind.push_back(kind);
    q_id.push_back(node_c_id);
    q_data.push_back(16'h0000);
  endtask

  task automatic check_outputs(input string where);
    assert (cfg_a_o == exp_a) else begin
      $display("Error at %0t ns: node A after %s expected %h, got %h",
               $time, where, exp_a, cfg_a_o);
      check_errors++;
    end
    assert (cfg_b_o == exp_b) else begin
      $display("Error at %0t ns: node B after %s expected %h, got %h",
               $time, where, exp_b, cfg_b_o);
      check_errors++;
    end
    assert (cfg_c_o == exp_c) else begin
      $display("Error at %0t ns: node C after %s expected %h, got %h",
               $time, where, exp_c, cfg_c_o);
      check_errors++;
    end
  endtask

  // Sends the queued requests with the request held through busy,
  // and checks all nodes 3 cycles after each frame ends
  task automatic run_queued();
    int n;
    n = q_kind.size();
    while (busy_o) begin
      @(posedge clk_i);
      #2;
    end
    drive_request(0);
    do begin
      @(posedge clk_i);
      #2;
    end while (!busy_o);
    for (int i = 0; i < n; i++) begin
      // Frame i is latched, so the next request may wait on the inputs
      if (i + 1 < n) begin
        drive_request(i + 1);
      end else begin
        drive_idle();
      end
      do begin
        @(posedge clk_i);
        #2;
      end while (busy_o);
      repeat (3) @(posedge clk_i);
      #2;
      model_apply(i);
      check_outputs($sformatf("frame %0d", i));
    end
    q_kind.delete();
    q_id.delete();
    q_data.delete();
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (check_errors == errors_before) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, check_errors - errors_before);
    end
  endtask

  task automatic test_reset_defaults();
    int errs;
    errs = check_errors;
    check_outputs("reset");
    report_test("reset_defaults", errs);
  endtask

  task automatic test_write_each_node();
    int errs;
    errs = check_errors;
    queue_write(node_a_id, 16'hA5C3);         // Node A keeps C3
    queue_write(node_b_id, 16'h9E71);         // Node B keeps E71
    queue_write(node_c_id, 16'h6D2B);
    run_queued();
    report_test("write_each_node", errs);
  endtask

  task automatic test_unassigned_ids();
    int errs;
    errs = check_errors;
    queue_write(4'd9, 16'h0F0F);
    queue_write(4'd5, 16'hFFFF);
    run_queued();
    report_test("unassigned_ids", errs);
  endtask

  task automatic test_back_to_back();
    int errs;
    errs = check_errors;
    queue_write(node_a_id, 16'hFFFE);         // Payloads that look like headers
    queue_write(node_b_id, 16'h0010);
    queue_write(node_c_id, 16'hFFFE);
    queue_write(node_a_id, 16'h0010);         // Later write to A must win
    queue_write(node_b_id, 16'h8421);
    run_queued();
    report_test("back_to_back", errs);
  endtask

  task automatic test_broadcast_reset();
    int errs;
    errs = check_errors;
    queue_write(node_a_id, 16'h1111);
    queue_write(node_b_id, 16'h2222);
    queue_write(node_c_id, 16'h3333);
    queue_reset_all(kind_both);
    queue_write(node_b_id, 16'h0ABC);
    queue_reset_all(kind_reset);
    run_queued();
    report_test("broadcast_reset", errs);
  endtask

  task automatic test_random();
    int                  errs;
    logic [31:0]         r;
    logic [cfg_id_w-1:0] id;
    errs = check_errors;
    for (int i = 0; i < 20; i++) begin
      r  = lcg_next();
      id = cfg_id_w'((lcg_next() >> 16) % 5);  // IDs 0 to 4
      if (r[31:29] == 3'd0 || i == 12) begin
        queue_reset_all(kind_reset);
      end else begin
        queue_write(id, r[27:12]);
      end
    end
    run_queued();
    report_test("random", errs);
  endtask

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    clk_i = 1'b0;
    reset = 1'b1;
    drive_idle();
    model_defaults();
    repeat (16) @(posedge clk_i);
    #2;
    reset = 1'b0;

    test_reset_defaults();
    test_write_each_node();
    test_unassigned_ids();
    test_back_to_back();
    test_broadcast_reset();
    test_random();

    $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
             tests_passed, tests_failed, check_errors);
    if (tests_failed == 0 && check_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/cfg_chain_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cfg_chain_top
  import cfg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset,
  input  logic                  wr_valid_i,   // Host write request
  input  logic [cfg_id_w-1:0]   wr_id_i,
  input  logic [cfg_data_w-1:0] wr_data_i,
  input  logic                  reset_all_i,  // Host broadcast reset request
  output logic                  busy_o,       // Serializer sending a frame
  output logic [7:0]            cfg_a_o,      // Node A mode
  output logic [11:0]           cfg_b_o,      // Node B mode
  output logic [15:0]           cfg_c_o       // Node C mode
);

  logic cfg_bit;                              // Shared serial line

  cfg_serializer cfg_serializer_inst (
    .clk_i       (clk_i),
    .reset       (reset),
    .wr_valid_i  (wr_valid_i),
    .wr_id_i     (wr_id_i),
    .wr_data_i   (wr_data_i),
    .reset_all_i (reset_all_i),
    .bit_o       (cfg_bit),
    .busy_o      (busy_o)
  );

  // All nodes listen to the same line on the same clock
  cfg_node #(
    .node_id_p     (4'd1),
    .config_bits_p (8),
    .default_p     (8'h5A)
  ) node_a_inst (
    .clk_i    (clk_i),
    .reset    (reset),
    .bit_i    (cfg_bit),
    .config_o (cfg_a_o)
  );

  cfg_node #(
    .node_id_p     (4'd2),
    .config_bits_p (12),
    .default_p     (12'h3C0)
  ) node_b_inst (
    .clk_i    (clk_i),
    .reset    (reset),
    .bit_i    (cfg_bit),
    .config_o (cfg_b_o)
  );

  cfg_node #(
    .node_id_p     (4'd3),
    .config_bits_p (16),
    .default_p     (16'hBEEF)
  ) node_c_inst (
    .clk_i    (clk_i),
    .reset    (reset),
    .bit_i    (cfg_bit),
    .config_o (cfg_c_o)
  );

endmodule

`default_nettype wire

/* source/cfg_node.sv */
`timescale 1ns/10ps
`default_nettype none

module cfg_node
  import cfg_pkg::*;
#(
  parameter logic [cfg_id_w-1:0]      node_id_p     = 1,   // Must not be cfg_reserved_id
  parameter int                       config_bits_p = 8,   // Up to cfg_data_w
  parameter logic [config_bits_p-1:0] default_p     = '0   // Value after any reset
)(
  input  logic                     clk_i,
  input  logic                     reset,
  input  logic                     bit_i,     // Serial line
  output logic [config_bits_p-1:0] config_o   // Mode register
);

  cfg_frame_u           shift_q;              // Last cfg_frame_w line bits
  logic [cfg_len_w-1:0] skip_q;               // Positions still to ignore
  logic                 bcast_reset;          // Window holds a broadcast reset
  logic                 header_seen;          // Window holds a frame header
  logic                 id_match;             // Header is addressed to this node

  // New bits enter at the top, so the oldest bit sits at position 0
  always_ff @(posedge clk_i) begin
    if (reset) begin
      shift_q.raw <= '0;                      // Same as an idle line
    end else begin
      shift_q.raw <= {bit_i, shift_q.raw[cfg_frame_w-1:1]};
    end
  end

  assign bcast_reset = &shift_q.raw;

  // Idle zeros in front of a frame never carry the skip value,
  // so only a window aligned to a real frame start passes here
  assign header_seen = (skip_q == '0) && !shift_q.fields.start
                       && (shift_q.fields.len == cfg_len_w'(cfg_skip_len));

  assign id_match = (shift_q.fields.id == node_id_p) && (node_id_p != cfg_reserved_id);

  always_ff @(posedge clk_i) begin
    if (reset) begin
      skip_q   <= '0;
      config_o <= default_p;
    end else if (bcast_reset) begin
      skip_q   <= '0;
      config_o <= default_p;
    end else if (header_seen) begin
      // Every node skips the payload, matching or not
      skip_q <= shift_q.fields.len;
      if (id_match) begin
        config_o <= shift_q.fields.data[config_bits_p-1:0];  // Low payload bits
      end
    end else if (skip_q != '0) begin
      skip_q <= skip_q - 1'b1;                // Bottom bit belongs to the payload
    end
  end

endmodule

`default_nettype wire

/* source/cfg_serializer.sv */
`timescale 1ns/10ps
`default_nettype none

module cfg_serializer
  import cfg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset,
  input  logic                  wr_valid_i,   // Write request
  input  logic [cfg_id_w-1:0]   wr_id_i,      // Target node ID
  input  logic [cfg_data_w-1:0] wr_data_i,    // Payload
  input  logic                  reset_all_i,  // Broadcast reset request
  output logic                  bit_o,        // Serial line, registered
  output logic                  busy_o        // High while a frame goes out
);

  cfg_frame_u           next_frame;           // Frame built from the request
  cfg_frame_u           shift_q;              // Bits still to send
  logic [cfg_len_w-1:0] bit_cnt_q;            // Bits left after the current one
  logic                 take_req;             // Request accepted this edge

  // Requests are only taken while the line is free
  assign take_req = !busy_o && (wr_valid_i || reset_all_i);

  // Broadcast reset beats a write when both are raised
  always_comb begin
    next_frame.fields.start = 1'b0;
    next_frame.fields.len   = cfg_len_w'(cfg_skip_len);
    next_frame.fields.id    = wr_id_i;
    next_frame.fields.data  = wr_data_i;
    if (reset_all_i) begin
      next_frame.raw = '1;                    // All ones marks a broadcast reset
    end
  end

  // Frame payload, shifted right so bit 0 is always the next to send
  always_ff @(posedge clk_i) begin
    if (take_req) begin
      shift_q.raw <= next_frame.raw >> 1;     // Bit 0 leaves on the accept edge
    end else if (busy_o) begin
      shift_q.raw <= shift_q.raw >> 1;
    end
  end

  // Line driver and frame length counter
  always_ff @(posedge clk_i) begin
    if (reset) begin
      busy_o    <= 1'b0;
      bit_o     <= 1'b0;
      bit_cnt_q <= '0;
    end else if (take_req) begin
      busy_o    <= 1'b1;
      bit_o     <= next_frame.raw[0];
      bit_cnt_q <= cfg_len_w'(cfg_frame_w - 1);
    end else if (busy_o && (bit_cnt_q != '0)) begin
      bit_o     <= shift_q.raw[0];
      bit_cnt_q <= bit_cnt_q - 1'b1;
    end else begin
      // Last bit has been on the line for one cycle
      busy_o    <= 1'b0;
      bit_o     <= 1'b0;                      // Line idles at zero
    end
  end

endmodule

`default_nettype wire

/* source/cfg_pkg.sv */
`default_nettype none

package cfg_pkg;

  // Field widths of one frame on the serial line
  localparam int cfg_id_w   = 4;                // Node ID field
  localparam int cfg_len_w  = 5;                // Skip-length field
  localparam int cfg_data_w = 16;               // Payload field

  // Start bit plus the three fields
  localparam int cfg_frame_w = 1 + cfg_len_w + cfg_id_w + cfg_data_w;

  // Positions a node ignores after a header, so the rest of the frame is skipped
  localparam int cfg_skip_len = cfg_frame_w - 1;

  // The idle line reads as ID 0, so no node may own it
  localparam logic [cfg_id_w-1:0] cfg_reserved_id = '0;

  // Field view of a frame, top bit down, sent LSB first
  typedef struct packed {
    logic [cfg_data_w-1:0] data;                // Payload, low bits used by the node
    logic [cfg_id_w-1:0]   id;                  // Target node
    logic [cfg_len_w-1:0]  len;                 // Skip length
    logic                  start;               // Always zero in a header
  } cfg_fields_t;

  // Same frame word seen as raw bits or as decoded fields
  typedef union packed {
    logic [cfg_frame_w-1:0] raw;                // Shift and all-ones views
    cfg_fields_t            fields;             // Header decode view
  } cfg_frame_u;

endpackage

`default_nettype wire
